/* include/microOp_settings.svh */
// Width and size constants for the micro-op expander, included by the package and the RTL
`ifndef MICROOP_SETTINGS_SVH
`define MICROOP_SETTINGS_SVH

// Instruction and micro-op word width
`define INSTR_WIDTH 32

// Architectural registers, also the LDM/STM list length
`define REG_COUNT 16

// Byte distance between consecutive block-transfer words
`define WORD_STEP 4

`endif

/* project.f */
+incdir+include
rtl/microOpPkg.sv
rtl/conditionCheck.sv
rtl/transferRegSelect.sv
rtl/microOpSequencer.sv
rtl/microOpExpander.sv
verification/microOp_properties.sv
verification/microOpExpander_tb.sv

/* rtl/conditionCheck.sv */
// ARM condition evaluator, used by the expander to flush failed block transfers
`timescale 1ns/1ps

module conditionCheck (
	input microOpPkg::regIndex cond, // Instruction bits 31:28
	input microOpPkg::flagVec flags, // NZCV
	output logic condPass
);

	logic negative;
	logic zero;
	logic carry;
	logic overflow;

	assign {negative, zero, carry, overflow} = flags;

	always_comb begin
		case (cond)
			4'b0000: condPass = zero; // EQ
			4'b0001: condPass = ~zero; // NE
			4'b0010: condPass = carry; // CS
			4'b0011: condPass = ~carry; // CC
			4'b0100: condPass = negative; // MI
			4'b0101: condPass = ~negative; // PL
			4'b0110: condPass = overflow; // VS
			4'b0111: condPass = ~overflow; // VC
			4'b1000: condPass = carry & ~zero; // HI
			4'b1001: condPass = ~carry | zero; // LS
			4'b1010: condPass = (negative == overflow); // GE
			4'b1011: condPass = (negative != overflow); // LT
			4'b1100: condPass = ~zero & (negative == overflow); // GT
			4'b1101: condPass = zero | (negative != overflow); // LE
			4'b1110: condPass = 1'b1; // AL
			default: condPass = 1'b0; // NV, used for the flush no-op
		endcase
	end

endmodule

/* rtl/microOpExpander.sv */
// Top of the decode-stage micro-op expander, connects sequencer, condition check and register pick
`timescale 1ns/1ps

module microOpExpander (
	input logic clk,
	input logic reset,
	input logic freeze, // Held by later stages
	input microOpPkg::instrWord instr, // Instruction in decode
	input microOpPkg::flagVec flags,
	output microOpPkg::instrWord uopInstr,
	output microOpPkg::uopCtrl ctrl,
	output logic uopStall // Fetch holds instr while high
);

	logic condPass;
	logic first; // Sequencer in ready
	microOpPkg::regList pending;
	microOpPkg::regList remaining;
	microOpPkg::regIndex nextReg;

	conditionCheck condCheck (
		.cond(instr[31:28]),
		.flags(flags),
		.condPass(condPass)
	);

	transferRegSelect regSelect (
		.instr(instr),
		.first(first),
		.pending(pending),
		.nextReg(nextReg),
		.remaining(remaining)
	);

	microOpSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.instr(instr),
		.condPass(condPass),
		.nextReg(nextReg),
		.remaining(remaining),
		.first(first),
		.pending(pending),
		.uopInstr(uopInstr),
		.ctrl(ctrl),
		.uopStall(uopStall)
	);

endmodule

/* rtl/microOpPkg.sv */
// Shared types of the micro-op expander, referenced from the RTL by scoped names
`include "microOp_settings.svh"

package microOpPkg;

	typedef logic [`INSTR_WIDTH-1:0] instrWord; // Fetched instruction or emitted micro-op
	typedef logic [`REG_COUNT-1:0] regList; // LDM/STM register bitmap
	typedef logic [$clog2(`REG_COUNT)-1:0] regIndex; // Register number, also cond field width
	typedef logic [3:0] flagVec; // N Z C V, MSB first

	// Sequencer states, one per split form plus the idle state
	typedef enum logic [2:0] {
		ready, // Idle, first micro-op or pass-through
		rsr, // Operation after the shift into Rz
		multiply, // Accumulate after the multiply into Rz
		blockTransfer, // Remaining single transfers of LDM/STM
		baseUpdate, // Writeback of Rn after the last transfer
		branchLink // Plain branch after the link move
	} seqState;

	// Datapath control bundle sent with each micro-op
	typedef struct packed {
		logic instrMux; // Micro-op replaces fetched word
		logic noFlagUpdate; // Suppress NZCV write
		logic ldmForward; // Forward base to later transfers
		logic prevRsr; // Second micro-op of a split form
		logic keepV; // Hold V across multiply
		logic [3:0] regFileRz; // [3] RA1 mux, [2:0] fifth address bit of WA3 RA2 RA1
	} uopCtrl;

endpackage

/* rtl/microOpSequencer.sv */
// Mealy FSM of the expander, splits RSR, MAC, BL and LDM/STM into micro-ops with control bits
`timescale 1ns/1ps
`include "microOp_settings.svh"

module microOpSequencer (
	input logic clk,
	input logic reset,
	input logic freeze, // Back-pressure, holds all state
	input microOpPkg::instrWord instr,
	input logic condPass,
	input microOpPkg::regIndex nextReg,
	input microOpPkg::regList remaining,
	output logic first,
	output microOpPkg::regList pending,
	output microOpPkg::instrWord uopInstr,
	output microOpPkg::uopCtrl ctrl,
	output logic uopStall
);

	microOpPkg::seqState state, nextState;
	microOpPkg::regList pendingNext;
	logic [$clog2(`REG_COUNT):0] xferCount, countNext; // Transfers already issued
	logic [$clog2(`REG_COUNT):0] numRegs; // Registers in the LDM/STM list

	logic isRsr, isMac, isBranchLink, isBlock;
	logic lastXfer; // No register left after this transfer
	logic writeBack; // W bit
	logic upBit; // U bit
	logic [11:0] blockSize; // 4n
	logic [11:0] startMag; // Magnitude of the first offset
	logic [11:0] xferStep; // 4k
	logic [11:0] xferOffset; // Magnitude of the offset of transfer k
	microOpPkg::instrWord xferWord; // Single-word transfer micro-op
	microOpPkg::instrWord updateWord; // Base writeback micro-op

	assign first = (state == microOpPkg::ready);

	// Split form decode, only meaningful in ready
	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4];
	assign isBlock = (instr[27:25] == 3'b100) && (instr[`REG_COUNT-1:0] != '0); // Empty list passes
	assign isBranchLink = (instr[27:24] == 4'b1011);
	assign isMac = (instr[27:24] == 4'b0000) && instr[21] && (instr[7:4] == 4'b1001);

	assign lastXfer = (remaining == '0);
	assign writeBack = instr[21];
	assign upBit = instr[23];
	assign numRegs = ($clog2(`REG_COUNT)+1)'($countones(instr[`REG_COUNT-1:0]));

	// Offset arithmetic for the four addressing modes
	always_comb begin
		blockSize = 12'(numRegs) * 12'(`WORD_STEP);
		xferStep = 12'(xferCount) * 12'(`WORD_STEP);
		case (instr[24:23]) // P U
			2'b01: startMag = '0; // IA
			2'b11: startMag = 12'(`WORD_STEP); // IB
			2'b00: startMag = blockSize - 12'(`WORD_STEP); // DA, -4(n-1)
			default: startMag = blockSize; // DB, -4n
		endcase
		xferOffset = upBit ? (startMag + xferStep) : (startMag - xferStep); // U gives the sign
	end

	// Pre-indexed word LDR/STR without writeback, Rd from the selector
	assign xferWord = {instr[31:28], 3'b010, 1'b1, upBit, 1'b0, 1'b0, instr[20],
		instr[19:16], nextReg, xferOffset};

	// ADD or SUB Rn, Rn, #4n, 4n fits the 8-bit immediate with zero rotate
	assign updateWord = {instr[31:28], 3'b001, (upBit ? 4'b0100 : 4'b0010), 1'b0,
		instr[19:16], instr[19:16], blockSize};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= microOpPkg::ready;
			pending <= '0;
			xferCount <= '0;
		end else if (!freeze) begin
			state <= nextState;
			pending <= pendingNext;
			xferCount <= countNext;
		end
	end

	always_comb begin
		nextState = microOpPkg::ready;
		pendingNext = '0;
		countNext = '0;
		uopInstr = instr; // Pass-through
		ctrl = '0;
		uopStall = 1'b0;
		case (state)
			microOpPkg::ready: begin
				if (isRsr) begin
					uopInstr = {instr[31:25], 4'b1101, 1'b0, 4'b0000, 4'b1111, instr[11:0]}; // MOV Rz, shifted Rm
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.regFileRz = 4'b1100; // Rd field selects Rz
					uopStall = 1'b1;
					nextState = microOpPkg::rsr;
				end else if (isBlock) begin
					uopInstr = xferWord; // Transfer k = 0
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					if (!lastXfer) begin
						uopStall = 1'b1;
						pendingNext = remaining;
						countNext = xferCount + 1'b1;
						nextState = microOpPkg::blockTransfer;
					end else if (writeBack) begin
						uopStall = 1'b1;
						nextState = microOpPkg::baseUpdate;
					end
				end else if (isBranchLink) begin
					uopInstr = {instr[31:28], 3'b000, 4'b1101, 1'b0, 4'b0000, 4'b1110, 8'h00, 4'b1111}; // MOV R14, R15
					ctrl.instrMux = 1'b1;
					uopStall = 1'b1;
					nextState = microOpPkg::branchLink;
				end else if (isMac) begin
					uopInstr = {instr[31:24], 1'b0, instr[22], 1'b0, 1'b0, 4'b1111, 4'b0000, instr[11:0]}; // MUL Rz
					ctrl.instrMux = 1'b1;
					ctrl.keepV = 1'b1;
					ctrl.regFileRz = 4'b1100;
					uopStall = 1'b1;
					nextState = microOpPkg::multiply;
				end
			end
			microOpPkg::rsr: begin
				uopInstr = {instr[31:12], 8'h00, 4'b1111}; // Same op, Rz unshifted
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.regFileRz = 4'b0010; // Rm field reads Rz
			end
			microOpPkg::multiply: begin
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				if (!instr[23]) begin
					uopInstr = {instr[31:28], 7'b0000100, instr[20], 4'b1111, instr[19:16],
						8'h00, instr[15:12]}; // ADD Rd, Rz, Rn
					ctrl.regFileRz = 4'b0001; // Rn field reads Rz
				end else begin
					uopInstr = {instr[31:12], instr[15:12], 4'b1001, instr[19:16]}; // RdLo and RdHi to multiplier
				end
			end
			microOpPkg::blockTransfer: begin
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				if (!condPass) begin
					uopInstr = {4'b1111, 3'b001, 4'b0100, 1'b0, 20'h00000}; // Never-execute ADD R0, R0, #0
				end else begin
					uopInstr = xferWord;
					ctrl.ldmForward = 1'b1;
					if (!lastXfer) begin
						uopStall = 1'b1;
						pendingNext = remaining;
						countNext = xferCount + 1'b1;
						nextState = microOpPkg::blockTransfer;
					end else if (writeBack) begin
						uopStall = 1'b1;
						nextState = microOpPkg::baseUpdate;
					end
				end
			end
			microOpPkg::baseUpdate: begin
				uopInstr = updateWord;
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.ldmForward = 1'b1;
			end
			microOpPkg::branchLink: begin
				uopInstr = {instr[31:25], 1'b0, instr[23:0]}; // Link bit cleared
				ctrl.instrMux = 1'b1;
			end
			default: begin
				nextState = microOpPkg::ready; // Unused encodings recover
			end
		endcase
	end

endmodule

/* rtl/transferRegSelect.sv */
// Register picker for LDM/STM, gives the lowest listed register and the list left after it
`timescale 1ns/1ps
`include "microOp_settings.svh"

module transferRegSelect (
	input microOpPkg::instrWord instr,
	input logic first, // High on the first transfer, list comes from instr
	input microOpPkg::regList pending, // List still to transfer on later cycles
	output microOpPkg::regIndex nextReg,
	output microOpPkg::regList remaining
);

	microOpPkg::regList source; // List the pick is taken from
	microOpPkg::regList pickMask; // One-hot of the chosen register

	assign source = first ? instr[`REG_COUNT-1:0] : pending;

	// Priority pick, lower bits override so the lowest set bit wins
	always_comb begin
		nextReg = '0; // Register 0 when the list is empty
		for (int i = `REG_COUNT - 1; i >= 0; i--) begin
			if (source[i]) begin
				nextReg = microOpPkg::regIndex'(i);
			end
		end
	end

	assign pickMask = microOpPkg::regList'(1) << nextReg;
	assign remaining = source & ~pickMask; // Empty stays empty

endmodule

/* verification/microOpExpander_tb.sv */
// Table-driven testbench of the micro-op expander, applies each instruction and checks its micro-ops
`timescale 1ns/1ps
`include "microOp_settings.svh"

module microOpExpander_tb;

	localparam int clockPeriod = 8; // ns
	localparam int numTests = 20;
	localparam int maxUops = `REG_COUNT + 1; // Full list plus base update

	// One table row, ctrl written as {instrMux noFlagUpdate ldmForward prevRsr keepV}_{regFileRz}
	typedef struct packed {
		microOpPkg::instrWord instr;
		microOpPkg::flagVec flags;
		logic [4:0] count; // Expected micro-ops
		microOpPkg::instrWord firstWord;
		microOpPkg::instrWord lastWord;
		microOpPkg::uopCtrl firstCtrl;
		microOpPkg::uopCtrl lastCtrl;
	} testVector;

	logic clk;
	logic reset;
	logic freeze;
	microOpPkg::instrWord instr;
	microOpPkg::flagVec flags;
	microOpPkg::instrWord uopInstr;
	microOpPkg::uopCtrl ctrl;
	logic uopStall;

	testVector vectors [numTests];
	string testNames [numTests];
	int fillIndex = 0; // Next free table row
	int mismatchCount = 0;
	int failCount = 0; // Failures other than wrong values

	microOpExpander microOpExpander_inst (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.instr(instr),
		.flags(flags),
		.uopInstr(uopInstr),
		.ctrl(ctrl),
		.uopStall(uopStall)
	);

	bind microOpExpander microOpProperties propertyCheck (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.instr(instr),
		.flags(flags),
		.uopInstr(uopInstr),
		.ctrl(ctrl),
		.uopStall(uopStall),
		.inReady(first)
	);

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	// Watchdog sized for up to eight cycles per row
	initial begin
		#((numTests * 8 + 50) * clockPeriod);
		$display("Watchdog expired before the test table finished");
		$display("Test failed");
		$finish;
	end

	task automatic addTest(input string name, input microOpPkg::instrWord word,
		input microOpPkg::flagVec flagValue, input int count,
		input microOpPkg::instrWord firstWord, input microOpPkg::instrWord lastWord,
		input microOpPkg::uopCtrl firstCtrl, input microOpPkg::uopCtrl lastCtrl);
		if (fillIndex >= numTests) begin
			failCount++;
			$display("Test table overflow at %s", name);
		end else begin
			testNames[fillIndex] = name;
			vectors[fillIndex].instr = word;
			vectors[fillIndex].flags = flagValue;
			vectors[fillIndex].count = 5'(count);
			vectors[fillIndex].firstWord = firstWord;
			vectors[fillIndex].lastWord = lastWord;
			vectors[fillIndex].firstCtrl = firstCtrl;
			vectors[fillIndex].lastCtrl = lastCtrl;
			fillIndex++;
		end
	endtask

	// Expected words worked out by hand from the encodings
	task automatic loadTable();
		addTest("passDp", 32'hE082_1003, 4'b1010, 1, 32'hE082_1003, 32'hE082_1003,
			10'b0, 10'b0);
		addTest("passLdr", 32'hE591_0004, 4'b0000, 1, 32'hE591_0004, 32'hE591_0004,
			10'b0, 10'b0);
		addTest("passB", 32'hEA00_0010, 4'b0000, 1, 32'hEA00_0010, 32'hEA00_0010,
			10'b0, 10'b0);
		addTest("rsrAdd", 32'hE082_1413, 4'b0000, 2, 32'hE1A0_F413, 32'hE082_100F,
			10'b11000_1100, 10'b10010_0010); // MOV Rz, R3 LSL R4
		addTest("mlaShort", 32'hE021_4392, 4'b0000, 2, 32'hE00F_0392, 32'hE08F_1004,
			10'b10001_1100, 10'b10010_0001);
		addTest("mlaLong", 32'hE0A2_1493, 4'b0000, 2, 32'hE00F_0493, 32'hE0A2_1192,
			10'b10001_1100, 10'b10010_0000); // UMLAL
		addTest("branchLink", 32'hEB00_0010, 4'b0000, 2, 32'hE1A0_E00F, 32'hEA00_0010,
			10'b10000_0000, 10'b10000_0000);
		addTest("ldmIa", 32'hE89D_0016, 4'b0000, 3, 32'hE59D_1000, 32'hE59D_4008,
			10'b11000_0000, 10'b11100_0000);
		addTest("ldmIaW", 32'hE8BD_0016, 4'b0000, 4, 32'hE59D_1000, 32'hE28D_D00C,
			10'b11000_0000, 10'b11100_0000); // ADD R13, R13, #12
		addTest("stmIb", 32'hE980_0028, 4'b0000, 2, 32'hE580_3004, 32'hE580_5008,
			10'b11000_0000, 10'b11100_0000);
		addTest("stmIbW", 32'hE9A0_0028, 4'b0000, 3, 32'hE580_3004, 32'hE280_0008,
			10'b11000_0000, 10'b11100_0000);
		addTest("ldmDa", 32'hE812_0083, 4'b0000, 3, 32'hE512_0008, 32'hE512_7000,
			10'b11000_0000, 10'b11100_0000); // Offsets -8, -4, 0
		addTest("ldmDaW", 32'hE832_0083, 4'b0000, 4, 32'hE512_0008, 32'hE242_200C,
			10'b11000_0000, 10'b11100_0000); // SUB R2, R2, #12
		addTest("stmDb", 32'hE90D_4070, 4'b0000, 4, 32'hE50D_4010, 32'hE50D_E004,
			10'b11000_0000, 10'b11100_0000);
		addTest("stmDbW", 32'hE92D_4070, 4'b0000, 5, 32'hE50D_4010, 32'hE24D_D010,
			10'b11000_0000, 10'b11100_0000); // Push
		addTest("ldmSingleW", 32'hE8B1_0008, 4'b0000, 2, 32'hE591_3000, 32'hE281_1004,
			10'b11000_0000, 10'b11100_0000);
		addTest("ldmEmpty", 32'hE891_0000, 4'b0000, 1, 32'hE891_0000, 32'hE891_0000,
			10'b0, 10'b0);
		addTest("ldmEqFail", 32'h089D_0016, 4'b0000, 2, 32'h059D_1000, 32'hF280_0000,
			10'b11000_0000, 10'b11000_0000); // Z clear
		addTest("ldmEqPass", 32'h089D_0016, 4'b0100, 3, 32'h059D_1000, 32'h059D_4008,
			10'b11000_0000, 10'b11100_0000);
		addTest("ldmNeFailW", 32'h18BD_0006, 4'b0100, 2, 32'h159D_1000, 32'hF280_0000,
			10'b11000_0000, 10'b11000_0000); // Flush skips base update
	endtask

	// Called 1 ns after a rising edge, returns at the same point after the last micro-op
	task automatic runTest(input int idx);
		microOpPkg::instrWord seen [$];
		microOpPkg::uopCtrl firstCtrl;
		microOpPkg::uopCtrl lastCtrl;
		microOpPkg::instrWord heldWord;
		int holdCycles;
		logic stallSeen;
		logic frozenSeen;
		seen.delete();
		firstCtrl = '0;
		lastCtrl = '0;
		heldWord = '0;
		instr = vectors[idx].instr;
		flags = vectors[idx].flags;
		stallSeen = 1'b1;
		while (stallSeen && seen.size() < maxUops) begin
			holdCycles = $urandom_range(3, 0);
			frozenSeen = 1'b0;
			repeat (holdCycles) begin
				freeze = 1'b1;
				@(negedge clk);
				heldWord = uopInstr; // Word shown while frozen
				frozenSeen = 1'b1;
				@(posedge clk);
				#1;
			end
			freeze = 1'b0;
			@(negedge clk);
			if (frozenSeen && uopInstr !== heldWord) begin
				mismatchCount++;
				$display("mismatch %s: frozen word expected %h actual %h",
					testNames[idx], heldWord, uopInstr);
			end
			if (seen.size() == 0) begin
				firstCtrl = ctrl;
			end
			lastCtrl = ctrl;
			seen.push_back(uopInstr);
			stallSeen = uopStall;
			@(posedge clk);
			#1;
		end
		if (stallSeen) begin
			failCount++;
			$display("Stall never fell during test %s", testNames[idx]);
		end
		if (seen.size() != vectors[idx].count) begin
			mismatchCount++;
			$display("mismatch %s: count expected %0d actual %0d",
				testNames[idx], vectors[idx].count, seen.size());
		end
		if (seen[0] !== vectors[idx].firstWord) begin
			mismatchCount++;
			$display("mismatch %s: first word expected %h actual %h",
				testNames[idx], vectors[idx].firstWord, seen[0]);
		end
		if (seen[seen.size() - 1] !== vectors[idx].lastWord) begin
			mismatchCount++;
			$display("mismatch %s: last word expected %h actual %h",
				testNames[idx], vectors[idx].lastWord, seen[seen.size() - 1]);
		end
		if (firstCtrl !== vectors[idx].firstCtrl) begin
			mismatchCount++;
			$display("mismatch %s: first ctrl expected %b actual %b",
				testNames[idx], vectors[idx].firstCtrl, firstCtrl);
		end
		if (lastCtrl !== vectors[idx].lastCtrl) begin
			mismatchCount++;
			$display("mismatch %s: last ctrl expected %b actual %b",
				testNames[idx], vectors[idx].lastCtrl, lastCtrl);
		end
	endtask

	initial begin
		reset = 1'b1;
		freeze = 1'b0;
		instr = '0;
		flags = '0;
		void'($urandom(24501)); // Fixed seed for the freeze pattern
		loadTable();
		if (fillIndex != numTests) begin
			failCount++;
			$display("Test table holds %0d rows instead of %0d", fillIndex, numTests);
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int t = 0; t < fillIndex; t++) begin
			runTest(t);
		end
		$display("Errors: %0d mismatches, %0d other failures over %0d tests",
			mismatchCount, failCount, fillIndex);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verification/microOp_properties.sv */
// Concurrent checks on stall, freeze and reset of the expander, bound into its top level
`timescale 1ns/1ps
`include "microOp_settings.svh"

module microOpProperties (
	input logic clk,
	input logic reset,
	input logic freeze,
	input microOpPkg::instrWord instr,
	input microOpPkg::flagVec flags,
	input microOpPkg::instrWord uopInstr,
	input microOpPkg::uopCtrl ctrl,
	input logic uopStall,
	input logic inReady // Sequencer state is ready
);

	logic [$clog2(`REG_COUNT)+1:0] stallRun; // Unfrozen cycles with stall high in a row

	always_ff @(posedge clk) begin
		if (reset || !uopStall) begin
			stallRun <= '0;
		end else if (!freeze) begin
			stallRun <= stallRun + 1'b1;
		end
	end

	// Reset brings the sequencer back to ready
	readyAfterReset: assert property (@(posedge clk) reset |=> inReady)
		else $error("sequencer not in ready after reset");

	// Pass-through word in ready never stalls fetch
	passNoStall: assert property (@(posedge clk) disable iff (reset)
		(inReady && uopInstr == instr) |-> (!uopStall && ctrl == '0))
		else $error("stall or control bits on a pass-through word");

	// Frozen cycle repeats its micro-op when the inputs are held
	freezeHolds: assert property (@(posedge clk) disable iff (reset)
		freeze |=> (!$stable(instr) || !$stable(flags) ||
			($stable(uopInstr) && $stable(ctrl))))
		else $error("micro-op changed while frozen");

	// Longest sequence is a full list plus the base update
	stallBounded: assert property (@(posedge clk) disable iff (reset)
		stallRun <= `REG_COUNT + 1)
		else $error("stall held beyond the longest sequence");

endmodule
